// ==== card_pkg.sv ====
/*
 * Bus, reset and control register definitions for the Apple II card glue.
 * Shared by the reset generator, the clock monitor, the APB register block
 * and the top level. Import with card_pkg::* in the module header.
 */

package card_pkg;

    // ==============================
    // apple bus and reset
    // ==============================
    typedef logic [7:0] a2_data_t;              // one byte on the apple data bus

    localparam logic [4:0] POR_CYCLES = 5'd16;  // device reset hold after arst
    localparam int EDGE_CNT_W = 11;             // activity counter, led on msb

    // ==============================
    // control register
    // ==============================
    typedef struct packed {
        logic [27:0] reserved;  // reads as zero
        logic irq_out_en;       // bit 3
        logic data_out_en;      // bit 2
        logic speaker_en;       // bit 1
        logic scanlines_en;     // bit 0
    } ctrl_fields_t;

    // apb sees the raw word, the logic sees the fields
    typedef union packed {
        logic [31:0] raw;
        ctrl_fields_t f;
    } ctrl_reg_u;

    localparam logic [31:0] CTRL_RESET = 32'h0000_000C;  // data and irq out on
    localparam logic [31:0] CTRL_WMASK = 32'h0000_000F;  // writable field bits

    typedef logic [3:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ADDR_CTRL = 4'h0;
    localparam apb_addr_t ADDR_STATUS = 4'h4;  // read only

endpackage

// ==== av_pkg.sv ====
/*
 * Audio sample and pixel definitions for the card audio mixer and the
 * scanline shader. Card samples are 10-bit unsigned and are placed into
 * a 13-bit range before the sum, which then fits a 16-bit signed sample.
 */

package av_pkg;

    // ==============================
    // audio
    // ==============================
    typedef logic [9:0] card_audio_t;         // unsigned card sample
    typedef logic signed [15:0] mix_sample_t;  // mixed stereo sample

    localparam int MIX_RANGE_W = 13;      // common range of every source
    localparam int CARD_AUDIO_SHIFT = 3;  // 10-bit sample to top of range
    localparam int SPEAKER_SHIFT = 12;    // 1-bit speaker to range msb

    // ==============================
    // video
    // ==============================
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

// ==== card_ctrl_if.sv ====
/*
 * Effective feature enables, driven by the APB register block and read by
 * the bus response mux, the audio mixer and the scanline shader.
 */

`timescale 1ns/1ps

interface card_ctrl_if;

    logic scanlines_en;  // darken odd lines
    logic speaker_en;    // add apple speaker to mix
    logic data_out_en;   // allow driving the data bus
    logic irq_out_en;    // allow driving irq

    modport regs (output scanlines_en, output speaker_en,
                  output data_out_en, output irq_out_en);

    modport user (input scanlines_en, input speaker_en,
                  input data_out_en, input irq_out_en);

endinterface

// ==== card_reset_gen.sv ====
/*
 * Power-on reset stretcher. Device reset follows arst immediately and is
 * held POR_CYCLES clocks after arst falls. System reset adds the Apple bus
 * reset on top of the device reset.
 */

`timescale 1ns/1ps

module card_reset_gen
    import card_pkg::*;
(
    input  logic clk_logic_w,
    input  logic arst,
    input  logic a2_reset_n_i,  // apple bus reset, low active
    output logic device_rst_o,
    output logic system_rst_o
);

    logic [4:0] por_cnt_r;  // same width as POR_CYCLES
    logic device_rst_r;

    // ==============================
    // stretch counter
    // ==============================
    always_ff @(posedge clk_logic_w or posedge arst) begin
        if (arst) begin
            por_cnt_r <= '0;
            device_rst_r <= 1'b1;  // assert at once
        end else if (device_rst_r) begin
            if (por_cnt_r == POR_CYCLES - 5'd1) begin
                device_rst_r <= 1'b0;  // release on the 16th edge
            end else begin
                por_cnt_r <= por_cnt_r + 5'd1;
            end
        end
    end

    assign device_rst_o = device_rst_r;

    // bus reset folded in, no extra delay
    assign system_rst_o = device_rst_r | ~a2_reset_n_i;

endmodule

// ==== a2_clock_monitor.sv ====
/*
 * Activity monitor for the Apple bus phi1 and q3 clocks. Each input passes
 * two synchroniser flops and one edge flop; a rising edge bumps its
 * counter three clocks after the pin rose. The counters wrap.
 */

`timescale 1ns/1ps

module a2_clock_monitor
    import card_pkg::*;
(
    input  logic clk_logic_w,
    input  logic system_rst_i,
    input  logic a2_phi1_i,
    input  logic a2_q3_i,
    output logic [EDGE_CNT_W-1:0] phi1_cnt_o,
    output logic [EDGE_CNT_W-1:0] q3_cnt_o
);

    // bit 0 phi1, bit 1 q3
    logic [1:0] meta_r;
    logic [1:0] sync_r;
    logic [1:0] last_r;
    logic [1:0] rise_w;

    always_ff @(posedge clk_logic_w or posedge system_rst_i) begin
        if (system_rst_i) begin
            meta_r <= '0;
            sync_r <= '0;
            last_r <= '0;
        end else begin
            meta_r <= {a2_q3_i, a2_phi1_i};  // async pins
            sync_r <= meta_r;
            last_r <= sync_r;                // edge reference
        end
    end

    assign rise_w = sync_r & ~last_r;

    always_ff @(posedge clk_logic_w or posedge system_rst_i) begin
        if (system_rst_i) begin
            phi1_cnt_o <= '0;
            q3_cnt_o <= '0;
        end else begin
            if (rise_w[0]) phi1_cnt_o <= phi1_cnt_o + 1'b1;  // wraps
            if (rise_w[1]) q3_cnt_o <= q3_cnt_o + 1'b1;
        end
    end

endmodule

// ==== apb_card_regs.sv ====
/*
 * APB slave with the card control register and a status readback.
 * Zero wait states: an access completes on the first edge with psel and
 * penable high. CTRL at 0x0 is read/write, STATUS at 0x4 is read only,
 * anything else answers with pslverr. The effective feature enables are
 * the register fields, with the DIP switches ORed into scanlines and speaker.
 */

`timescale 1ns/1ps

module apb_card_regs
    import card_pkg::*;
(
    input  logic clk_logic_w,
    input  logic device_rst_i,

    // apb slave
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    // status sources
    input  logic [3:0] dip_switches_n_i,  // low when pressed
    input  logic [EDGE_CNT_W-1:0] phi1_cnt_i,
    input  logic [EDGE_CNT_W-1:0] q3_cnt_i,

    card_ctrl_if.regs ctrl
);

    ctrl_reg_u ctrl_r;
    apb_data_t status_w;
    logic access_w;
    logic addr_ok_w;
    logic [3:0] dip_w;

    assign dip_w = ~dip_switches_n_i;  // 1 = switch on

    // ==============================
    // access decode
    // ==============================
    assign access_w = psel_i & penable_i;

    always_comb begin
        addr_ok_w = 1'b0;
        if (paddr_i == ADDR_CTRL) begin
            addr_ok_w = 1'b1;
        end else if (paddr_i == ADDR_STATUS) begin
            addr_ok_w = ~pwrite_i;  // status is read only
        end
    end

    assign pready_o = 1'b1;                   // never waits
    assign pslverr_o = access_w & ~addr_ok_w;

    // ==============================
    // control register
    // ==============================
    always_ff @(posedge clk_logic_w or posedge device_rst_i) begin
        if (device_rst_i) begin
            ctrl_r.raw <= CTRL_RESET;
        end else if (access_w && pwrite_i && paddr_i == ADDR_CTRL) begin
            ctrl_r.raw <= pwdata_i & CTRL_WMASK;  // reserved bits stay zero
        end
    end

    // ==============================
    // readback
    // ==============================
    assign status_w = {12'd0, dip_w, q3_cnt_i[7:0], phi1_cnt_i[7:0]};

    always_comb begin
        prdata_o = '0;
        if (paddr_i == ADDR_CTRL) begin
            prdata_o = ctrl_r.raw;
        end else if (paddr_i == ADDR_STATUS) begin
            prdata_o = status_w;
        end
    end

    // switches only add to scanlines and speaker
    assign ctrl.scanlines_en = ctrl_r.f.scanlines_en | dip_w[0];
    assign ctrl.speaker_en = ctrl_r.f.speaker_en | dip_w[1];
    assign ctrl.data_out_en = ctrl_r.f.data_out_en;
    assign ctrl.irq_out_en = ctrl_r.f.irq_out_en;

endmodule

// ==== bus_response_mux.sv ====
/*
 * Card read arbitration onto the Apple data bus. The first responder in
 * the order SuperSerial, SuperSprite, Mockingboard wins; with none, the
 * latched bus data passes. Also combines the open-drain card interrupts.
 * Purely combinational.
 */

`timescale 1ns/1ps

module bus_response_mux
    import card_pkg::*;
(
    input  logic ssc_rd_i,
    input  logic ssp_rd_i,
    input  logic mb_rd_i,
    input  a2_data_t ssc_data_i,
    input  a2_data_t ssp_data_i,
    input  a2_data_t mb_data_i,
    input  a2_data_t bus_data_i,
    input  logic ssc_irq_n_i,
    input  logic ssp_irq_n_i,
    input  logic mb_irq_n_i,
    output a2_data_t a2_d_o,
    output logic a2_d_dir_o,  // 1 = fpga drives the bus
    output logic a2_irq_n_o,

    card_ctrl_if.user ctrl
);

    // fixed priority
    always_comb begin
        if (ssc_rd_i) begin
            a2_d_o = ssc_data_i;
        end else if (ssp_rd_i) begin
            a2_d_o = ssp_data_i;
        end else if (mb_rd_i) begin
            a2_d_o = mb_data_i;
        end else begin
            a2_d_o = bus_data_i;  // nobody answering
        end
    end

    assign a2_d_dir_o = (ssc_rd_i | ssp_rd_i | mb_rd_i) & ctrl.data_out_en;

    // wired-and, held inactive when gated off
    assign a2_irq_n_o = ctrl.irq_out_en ? (ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i) : 1'b1;

endmodule

// ==== audio_mixer.sv ====
/*
 * Card audio mixer. Each 10-bit card sample and the 1-bit speaker are
 * placed into a common 13-bit range and summed into 16-bit stereo.
 * The speaker only counts when enabled. One cycle of latency.
 */

`timescale 1ns/1ps

module audio_mixer
    import av_pkg::*;
(
    input  logic clk_logic_w,
    input  logic device_rst_i,
    input  logic speaker_i,
    input  card_audio_t ssp_audio_i,
    input  card_audio_t mb_audio_l_i,
    input  card_audio_t mb_audio_r_i,
    output mix_sample_t audio_l_o,
    output mix_sample_t audio_r_o,

    card_ctrl_if.user ctrl
);

    logic [MIX_RANGE_W-1:0] ssp_ext_w;
    logic [MIX_RANGE_W-1:0] mb_l_ext_w;
    logic [MIX_RANGE_W-1:0] mb_r_ext_w;
    logic [MIX_RANGE_W-1:0] spk_ext_w;
    logic [15:0] sum_l_w;
    logic [15:0] sum_r_w;

    // ==============================
    // widen to common range
    // ==============================
    assign ssp_ext_w = MIX_RANGE_W'(ssp_audio_i) << CARD_AUDIO_SHIFT;
    assign mb_l_ext_w = MIX_RANGE_W'(mb_audio_l_i) << CARD_AUDIO_SHIFT;
    assign mb_r_ext_w = MIX_RANGE_W'(mb_audio_r_i) << CARD_AUDIO_SHIFT;
    assign spk_ext_w = MIX_RANGE_W'(speaker_i & ctrl.speaker_en) << SPEAKER_SHIFT;

    // sum stays below 2^15, never negative
    assign sum_l_w = 16'(ssp_ext_w) + 16'(mb_l_ext_w) + 16'(spk_ext_w);
    assign sum_r_w = 16'(ssp_ext_w) + 16'(mb_r_ext_w) + 16'(spk_ext_w);

    always_ff @(posedge clk_logic_w or posedge device_rst_i) begin
        if (device_rst_i) begin
            audio_l_o <= '0;  // silent out of reset
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_sample_t'(sum_l_w);
            audio_r_o <= mix_sample_t'(sum_r_w);
        end
    end

endmodule

// ==== scanline_shade.sv ====
/*
 * Scanline effect on the pixel stream. With scanlines on, pixels on odd
 * lines are drawn at half intensity. One cycle of latency.
 */

`timescale 1ns/1ps

module scanline_shade
    import av_pkg::*;
(
    input  logic clk_logic_w,
    input  logic device_rst_i,
    input  rgb_t rgb_i,
    input  logic screen_y_lsb_i,  // 1 = odd line
    output rgb_t rgb_o,

    card_ctrl_if.user ctrl
);

    logic shade_w;

    assign shade_w = ctrl.scanlines_en & screen_y_lsb_i;

    always_ff @(posedge clk_logic_w or posedge device_rst_i) begin
        if (device_rst_i) begin
            rgb_o <= '0;
        end else if (shade_w) begin
            rgb_o <= '{r: rgb_i.r >> 1, g: rgb_i.g >> 1, b: rgb_i.b >> 1};  // half
        end else begin
            rgb_o <= rgb_i;
        end
    end

endmodule

// ==== a2_card_top.sv ====
/*
 * Glue logic around the Apple II slot cards on one logic clock: reset,
 * bus clock activity, read arbitration and interrupts, audio mix,
 * scanlines and an APB control/status block. Card outputs come in as
 * plain ports. Instances and wires only.
 */

`timescale 1ns/1ps

module a2_card_top
    import card_pkg::*;
    import av_pkg::*;
(
    input  logic clk_logic_w,
    input  logic arst,

    // apple bus
    input  logic a2_reset_n_i,
    input  logic a2_phi1_i,
    input  logic a2_q3_i,
    output a2_data_t a2_d_o,
    output logic a2_d_dir_o,
    output logic a2_irq_n_o,

    // apb control link
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    input  logic [3:0] dip_switches_n_i,
    output logic [1:0] led_o,

    // card responses
    input  logic ssc_rd_i,
    input  logic ssp_rd_i,
    input  logic mb_rd_i,
    input  a2_data_t ssc_data_i,
    input  a2_data_t ssp_data_i,
    input  a2_data_t mb_data_i,
    input  a2_data_t bus_data_i,
    input  logic ssc_irq_n_i,
    input  logic ssp_irq_n_i,
    input  logic mb_irq_n_i,

    // audio
    input  logic speaker_i,
    input  card_audio_t ssp_audio_i,
    input  card_audio_t mb_audio_l_i,
    input  card_audio_t mb_audio_r_i,
    output mix_sample_t audio_l_o,
    output mix_sample_t audio_r_o,

    // video
    input  rgb_t rgb_i,
    input  logic screen_y_lsb_i,
    output rgb_t rgb_o
);

    logic device_rst_w;
    logic system_rst_w;
    logic [EDGE_CNT_W-1:0] phi1_cnt_w;
    logic [EDGE_CNT_W-1:0] q3_cnt_w;

    card_ctrl_if ctrl_if ();

    // ==============================
    // reset and bus clocks
    // ==============================
    card_reset_gen u_reset (
        .clk_logic_w  (clk_logic_w),
        .arst         (arst),
        .a2_reset_n_i (a2_reset_n_i),
        .device_rst_o (device_rst_w),
        .system_rst_o (system_rst_w)
    );

    a2_clock_monitor u_clk_mon (
        .clk_logic_w  (clk_logic_w),
        .system_rst_i (system_rst_w),
        .a2_phi1_i    (a2_phi1_i),
        .a2_q3_i      (a2_q3_i),
        .phi1_cnt_o   (phi1_cnt_w),
        .q3_cnt_o     (q3_cnt_w)
    );

    assign led_o = {q3_cnt_w[EDGE_CNT_W-1], phi1_cnt_w[EDGE_CNT_W-1]};  // activity blink

    // ==============================
    // control registers
    // ==============================
    apb_card_regs u_regs (
        .clk_logic_w      (clk_logic_w),
        .device_rst_i     (device_rst_w),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .dip_switches_n_i (dip_switches_n_i),
        .phi1_cnt_i       (phi1_cnt_w),
        .q3_cnt_i         (q3_cnt_w),
        .ctrl             (ctrl_if.regs)
    );

    // ==============================
    // data bus and interrupts
    // ==============================
    bus_response_mux u_bus_mux (
        .ssc_rd_i    (ssc_rd_i),
        .ssp_rd_i    (ssp_rd_i),
        .mb_rd_i     (mb_rd_i),
        .ssc_data_i  (ssc_data_i),
        .ssp_data_i  (ssp_data_i),
        .mb_data_i   (mb_data_i),
        .bus_data_i  (bus_data_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .a2_d_o      (a2_d_o),
        .a2_d_dir_o  (a2_d_dir_o),
        .a2_irq_n_o  (a2_irq_n_o),
        .ctrl        (ctrl_if.user)
    );

    // ==============================
    // audio and video
    // ==============================
    audio_mixer u_mixer (
        .clk_logic_w  (clk_logic_w),
        .device_rst_i (device_rst_w),
        .speaker_i    (speaker_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o),
        .ctrl         (ctrl_if.user)
    );

    scanline_shade u_shade (
        .clk_logic_w    (clk_logic_w),
        .device_rst_i   (device_rst_w),
        .rgb_i          (rgb_i),
        .screen_y_lsb_i (screen_y_lsb_i),
        .rgb_o          (rgb_o),
        .ctrl           (ctrl_if.user)
    );

endmodule

// ==== a2_card_properties.sv ====
/*
 * Concurrent assertions on the card glue top level, attached with bind.
 * Watches the data bus direction, the interrupt gate and the APB error.
 */

`timescale 1ns/1ps

module a2_card_properties (
    input logic clk_logic_w,
    input logic arst,
    input logic ssc_rd_i,
    input logic ssp_rd_i,
    input logic mb_rd_i,
    input logic d_dir_i,       // a2_d_dir_o of the top
    input logic irq_n_i,       // a2_irq_n_o of the top
    input logic irq_out_en_i,  // effective irq enable
    input logic psel_i,
    input logic penable_i,
    input logic pslverr_i
);

    // only drive the bus while a card answers
    dir_needs_read: assert property (@(posedge clk_logic_w) disable iff (arst)
        d_dir_i |-> (ssc_rd_i || ssp_rd_i || mb_rd_i))
        else $error("data bus driven with no card read active");

    // irq gate closed means irq stays high
    irq_needs_enable: assert property (@(posedge clk_logic_w) disable iff (arst)
        !irq_n_i |-> irq_out_en_i)
        else $error("irq asserted while irq output disabled");

    // error flag only in the access phase
    slverr_in_access: assert property (@(posedge clk_logic_w) disable iff (arst)
        !(psel_i && penable_i) |-> !pslverr_i)
        else $error("pslverr high outside an apb access");

endmodule

// ==== tb_a2_card.sv ====
/*
 * Directed testbench for the Apple II card glue top level.
 * Runs reset defaults, read priority, interrupt combine, audio mix,
 * scanlines and bus clock activity, one task each, then prints counts.
 */

`timescale 1ns/1ps

module tb_a2_card
    import card_pkg::*;
    import av_pkg::*;
();

    localparam int CLK_NS = 10;
    // rough cycles: reset, then the six tests in order
    localparam int TEST_CYCLES = 25 + 25 + 35 + 30 + 65 + 65 + 160;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS;

    logic clk_logic_w;
    logic arst;
    logic a2_reset_n_i, a2_phi1_i, a2_q3_i;
    logic psel_i, penable_i, pwrite_i;
    apb_addr_t paddr_i;
    apb_data_t pwdata_i, prdata_o;
    logic pready_o, pslverr_o;
    logic [3:0] dip_switches_n_i;
    logic [1:0] led_o;
    logic ssc_rd_i, ssp_rd_i, mb_rd_i;
    a2_data_t ssc_data_i, ssp_data_i, mb_data_i, bus_data_i, a2_d_o;
    logic ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i;
    logic a2_d_dir_o, a2_irq_n_o;
    logic speaker_i;
    card_audio_t ssp_audio_i, mb_audio_l_i, mb_audio_r_i;
    mix_sample_t audio_l_o, audio_r_o;
    rgb_t rgb_i, rgb_o;
    logic screen_y_lsb_i;

    int tests = 0;
    int checks = 0;
    int errors = 0;
    logic [15:0] lfsr_state;

    a2_card_top dut (.*);

    bind a2_card_top a2_card_properties u_props (
        .clk_logic_w  (clk_logic_w),
        .arst         (arst),
        .ssc_rd_i     (ssc_rd_i),
        .ssp_rd_i     (ssp_rd_i),
        .mb_rd_i      (mb_rd_i),
        .d_dir_i      (a2_d_dir_o),
        .irq_n_i      (a2_irq_n_o),
        .irq_out_en_i (ctrl_if.irq_out_en),  // effective gate, not the raw bit
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pslverr_i    (pslverr_o)
    );

    initial clk_logic_w = 1'b0;
    always #(CLK_NS / 2) clk_logic_w = ~clk_logic_w;

    // ==============================
    // compare helpers
    // ==============================
    task automatic check_flag(input string what, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_data(input string what, input a2_data_t got, input a2_data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %02h, expected %02h", $time, what, got, want);
        end
    endtask

    task automatic check_word(input string what, input apb_data_t got, input apb_data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, want);
        end
    endtask

    task automatic check_sample(input string what, input mix_sample_t got,
                                input mix_sample_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_rgb(input string what, input rgb_t got, input rgb_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %06h, expected %06h", $time, what, got, want);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %-10s %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // ==============================
    // random source
    // ==============================
    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // ==============================
    // expected values
    // ==============================
    // rd bit 2 ssc, bit 1 ssp, bit 0 mb
    function automatic a2_data_t expect_read(input logic [2:0] rd, input a2_data_t ssc,
                                             input a2_data_t ssp, input a2_data_t mb,
                                             input a2_data_t bus);
        if (rd[2]) return ssc;
        if (rd[1]) return ssp;
        if (rd[0]) return mb;
        return bus;
    endfunction

    function automatic mix_sample_t expect_mix(input card_audio_t a, input card_audio_t b,
                                               input logic spk);
        int sum;
        sum = (int'(a) << CARD_AUDIO_SHIFT) + (int'(b) << CARD_AUDIO_SHIFT);
        if (spk) sum = sum + (1 << SPEAKER_SHIFT);
        return mix_sample_t'(sum);
    endfunction

    function automatic rgb_t expect_pixel(input rgb_t p, input logic shade);
        rgb_t q;
        q = p;
        if (shade) begin
            q.r = p.r / 2;  // half intensity
            q.g = p.g / 2;
            q.b = p.b / 2;
        end
        return q;
    endfunction

    // ==============================
    // apb master
    // ==============================
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(negedge clk_logic_w);
        psel_i = 1'b1;  // setup phase
        penable_i = 1'b0;
        pwrite_i = wr;
        paddr_i = addr;
        pwdata_i = wdata;
        @(negedge clk_logic_w);
        penable_i = 1'b1;  // access phase
        @(posedge clk_logic_w);
        while (!pready_o) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        rdata = prdata_o;  // still addressed here
        err = pslverr_o;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t ignored;
        apb_xfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic set_ctrl(input apb_data_t value);
        logic err;
        apb_write(ADDR_CTRL, value, err);
        check_flag("pslverr on CTRL write", err, 1'b0);
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic test_reset_defaults();
        int e0;
        apb_data_t rdata;
        logic err;
        e0 = errors;
        apb_read(ADDR_CTRL, rdata, err);
        check_word("CTRL after reset", rdata, CTRL_RESET);
        check_flag("pslverr on CTRL read", err, 1'b0);
        check_flag("pready_o", pready_o, 1'b1);
        apb_read(ADDR_STATUS, rdata, err);
        check_word("STATUS after reset", rdata, {12'd0, ~dip_switches_n_i, 16'd0});
        check_flag("a2_d_dir_o after reset", a2_d_dir_o, 1'b0);
        check_flag("a2_irq_n_o after reset", a2_irq_n_o, 1'b1);
        check_sample("audio_l_o after reset", audio_l_o, '0);
        check_sample("audio_r_o after reset", audio_r_o, '0);
        apb_read(4'h8, rdata, err);
        check_flag("pslverr on read of 0x8", err, 1'b1);
        apb_write(4'h8, 32'hFFFF_FFFF, err);
        check_flag("pslverr on write of 0x8", err, 1'b1);
        apb_write(ADDR_STATUS, 32'hFFFF_FFFF, err);
        check_flag("pslverr on STATUS write", err, 1'b1);
        apb_read(ADDR_CTRL, rdata, err);
        check_word("CTRL after bad writes", rdata, CTRL_RESET);  // nothing landed
        finish_test("reset", e0);
    endtask

    task automatic test_read_priority();
        int e0;
        logic [31:0] r;
        e0 = errors;
        for (int gate = 0; gate < 2; gate++) begin
            set_ctrl((gate == 0) ? CTRL_RESET : 32'h0000_0008);  // 2nd pass data out off
            for (int c = 0; c < 8; c++) begin
                @(negedge clk_logic_w);
                {ssc_rd_i, ssp_rd_i, mb_rd_i} = c[2:0];
                rand_bits(32, r);
                {ssc_data_i, ssp_data_i, mb_data_i, bus_data_i} = r;
                @(posedge clk_logic_w);  // combinational path, settled
                check_data("a2_d_o", a2_d_o,
                           expect_read(c[2:0], ssc_data_i, ssp_data_i, mb_data_i, bus_data_i));
                check_flag("a2_d_dir_o", a2_d_dir_o, (c != 0) && (gate == 0));
            end
        end
        @(negedge clk_logic_w);
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        set_ctrl(CTRL_RESET);
        finish_test("priority", e0);
    endtask

    task automatic test_irq_combine();
        int e0;
        e0 = errors;
        for (int gate = 0; gate < 2; gate++) begin
            set_ctrl((gate == 0) ? CTRL_RESET : 32'h0000_0004);  // 2nd pass irq out off
            for (int c = 0; c < 8; c++) begin
                @(negedge clk_logic_w);
                {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = c[2:0];
                @(posedge clk_logic_w);
                check_flag("a2_irq_n_o", a2_irq_n_o, (gate == 1) ? 1'b1 : (&c[2:0]));
            end
        end
        @(negedge clk_logic_w);
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        set_ctrl(CTRL_RESET);
        finish_test("irq", e0);
    endtask

    // mode 0 speaker off, 1 by register, 2 by dip switch 1
    task automatic test_audio_mix();
        int e0;
        logic [31:0] r;
        logic spk_on;
        mix_sample_t want_l, want_r;
        e0 = errors;
        for (int mode = 0; mode < 3; mode++) begin
            @(negedge clk_logic_w);
            dip_switches_n_i = (mode == 2) ? 4'b1101 : 4'b1111;
            set_ctrl((mode == 1) ? 32'h0000_000E : CTRL_RESET);
            for (int i = 0; i < 8; i++) begin
                @(negedge clk_logic_w);
                rand_bits(30, r);
                {ssp_audio_i, mb_audio_l_i, mb_audio_r_i} = r[29:0];
                speaker_i = i[0];
                spk_on = (mode != 0) && i[0];
                want_l = expect_mix(ssp_audio_i, mb_audio_l_i, spk_on);
                want_r = expect_mix(ssp_audio_i, mb_audio_r_i, spk_on);
                @(negedge clk_logic_w);  // one register stage
                check_sample("audio_l_o", audio_l_o, want_l);
                check_sample("audio_r_o", audio_r_o, want_r);
            end
        end
        @(negedge clk_logic_w);
        dip_switches_n_i = 4'b1111;
        speaker_i = 1'b0;
        set_ctrl(CTRL_RESET);
        finish_test("audio", e0);
    endtask

    // mode 0 scanlines off, 1 by register, 2 by dip switch 0
    task automatic test_scanlines();
        int e0;
        logic [31:0] r;
        rgb_t want;
        e0 = errors;
        for (int mode = 0; mode < 3; mode++) begin
            @(negedge clk_logic_w);
            dip_switches_n_i = (mode == 2) ? 4'b1110 : 4'b1111;
            set_ctrl((mode == 1) ? 32'h0000_000D : CTRL_RESET);
            for (int i = 0; i < 8; i++) begin
                @(negedge clk_logic_w);
                rand_bits(24, r);
                rgb_i = rgb_t'(r[23:0]);
                screen_y_lsb_i = i[0];  // odd and even lines in turn
                want = expect_pixel(rgb_i, (mode != 0) && i[0]);
                @(negedge clk_logic_w);
                check_rgb("rgb_o", rgb_o, want);
            end
        end
        @(negedge clk_logic_w);
        dip_switches_n_i = 4'b1111;
        screen_y_lsb_i = 1'b0;
        set_ctrl(CTRL_RESET);
        finish_test("scanlines", e0);
    endtask

    task automatic test_activity();
        int e0, n, m;
        logic [31:0] r;
        apb_data_t rdata;
        logic err;
        e0 = errors;
        rand_bits(4, r);
        n = int'(r[3:0]) + 3;
        rand_bits(4, r);
        m = int'(r[3:0]) + 3;
        rand_bits(4, r);
        @(negedge clk_logic_w);
        dip_switches_n_i = r[3:0];
        for (int i = 0; i < ((n > m) ? n : m); i++) begin
            @(negedge clk_logic_w);
            a2_phi1_i = (i < n);
            a2_q3_i = (i < m);
            repeat (4) @(negedge clk_logic_w);  // high longer than the sync delay
            a2_phi1_i = 1'b0;
            a2_q3_i = 1'b0;
            repeat (3) @(negedge clk_logic_w);
        end
        apb_read(ADDR_STATUS, rdata, err);
        check_word("STATUS counts", rdata, {12'd0, ~dip_switches_n_i, 8'(m), 8'(n)});
        check_flag("pslverr on STATUS read", err, 1'b0);
        // leds show the msb of each count
        check_flag("led_o phi1", led_o[0], n[EDGE_CNT_W-1]);
        check_flag("led_o q3", led_o[1], m[EDGE_CNT_W-1]);
        finish_test("activity", e0);
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        arst = 1'b1;
        a2_reset_n_i = 1'b1;
        a2_phi1_i = 1'b0;
        a2_q3_i = 1'b0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        dip_switches_n_i = 4'b1111;  // all released
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        {ssc_data_i, ssp_data_i, mb_data_i, bus_data_i} = '0;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        speaker_i = 1'b0;
        ssp_audio_i = '0;
        mb_audio_l_i = '0;
        mb_audio_r_i = '0;
        rgb_i = '0;
        screen_y_lsb_i = 1'b0;
        lfsr_state = 16'd41469;

        repeat (3) @(negedge clk_logic_w);
        arst = 1'b0;
        repeat (int'(POR_CYCLES) + 2) @(negedge clk_logic_w);  // stretcher done

        test_reset_defaults();
        test_read_priority();
        test_irq_combine();
        test_audio_mix();
        test_scanlines();
        test_activity();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== verilog.f ====
card_pkg.sv
av_pkg.sv
card_ctrl_if.sv
card_reset_gen.sv
a2_clock_monitor.sv
apb_card_regs.sv
bus_response_mux.sv
audio_mixer.sv
scanline_shade.sv
a2_card_top.sv
a2_card_properties.sv
tb_a2_card.sv

// ==== Makefile ====
# Verilator build and run for the Apple II card glue testbench

VERILATOR ?= verilator
TOP       ?= tb_a2_card
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
